// ==== common/sd_cmd_pkg.sv ====
// SD command frame definitions

package sd_cmd_pkg;

  // ==========================================================================
  // Frame geometry
  // ==========================================================================
  localparam int CMD_CONTENT_BITS = 40;  // Start, transmit, index, argument
  localparam int CRC_FIELD_BITS   = 8;   // 7 CRC bits plus end bit
  localparam int RESP_SHORT_BITS  = 39;  // R1/R3/R6/R7 body after start bit
  localparam int RESP_LONG_BITS   = 127; // R2 body after start bit

  // Field positions inside the 40-bit content
  localparam int FRAME_INDEX_LSB = 32;
  localparam int FRAME_INDEX_MSB = 37;

  // ==========================================================================
  // Field types
  // ==========================================================================
  typedef logic [5:0]                  cmd_index_t;
  typedef logic [31:0]                 cmd_arg_t;
  typedef logic [CMD_CONTENT_BITS-1:0] cmd_frame_t;
  typedef logic [6:0]                  crc7_t;

  // x^7 + x^3 + 1, the x^7 term is implicit
  localparam crc7_t CRC7_POLY = 7'h09;

  // Commands with special response handling
  localparam cmd_index_t CMD_ALL_SEND_CID  = 6'd2;  // Long R2 response
  localparam cmd_index_t CMD_GO_INACTIVE   = 6'd15; // No response at all
  localparam cmd_index_t ACMD_SEND_OP_COND = 6'd41; // R3, CRC field is all ones

endpackage

// ==== common/sd_host_pkg.sv ====
// SD host sequencer types

package sd_host_pkg;

  // Adjacent states differ in one bit along the normal path
  typedef enum logic [2:0] {
    IDLE      = 3'b000,
    SEND_CMD  = 3'b001,
    SEND_CRC  = 3'b011,
    WAIT_RESP = 3'b010,
    RCV_RESP  = 3'b110,
    RCV_CRC   = 3'b111
  } cmd_state_t;

  // Wide enough for the 127-bit R2 body
  typedef logic [7:0] bit_count_t;

  typedef logic [7:0] retry_count_t;

  // Retry counter stops here
  localparam retry_count_t RETRY_MAX = 8'hff;

endpackage

// ==== cmd_line/crc7.sv ====
// Serial CRC7 generator
`timescale 1ns/1ns

module crc7
  import sd_cmd_pkg::*;
(
  input  logic iclk,
  input  logic clear,   // Synchronous clear, also serves as reset
  input  logic data,    // Serial input, one bit per cycle
  input  logic unload,  // Shift remainder out instead of accumulating
  output logic crc_bit  // Remainder MSB
);

  crc7_t remainder;
  logic  feedback;

  assign feedback = data ^ remainder[6];

  always_ff @(posedge iclk) begin
    if (clear) begin
      remainder <= '0;
    end else if (unload) begin
      remainder <= {remainder[5:0], 1'b0}; // MSB first, zeros follow
    end else if (feedback) begin
      remainder <= {remainder[5:0], 1'b0} ^ CRC7_POLY;
    end else begin
      remainder <= {remainder[5:0], 1'b0};
    end
  end

  // Valid as the first CRC bit as soon as the last frame bit is absorbed
  assign crc_bit = remainder[6];

endmodule

// ==== cmd_line/cmd_driver.sv ====
// SD CMD line sequencer
`timescale 1ns/1ns

module cmd_driver
  import sd_cmd_pkg::*;
  import sd_host_pkg::*;
(
  input  logic       iclk,
  input  logic       irst,
  input  logic       req_go,
  input  cmd_index_t req_index,
  input  cmd_arg_t   req_arg,
  input  logic       cmd_in,    // From card, idles high
  output logic       cmd_out,   // To card, idles high
  output cmd_frame_t frame,
  output logic       done,
  output logic       crc_retry
);

  cmd_state_t state;
  cmd_state_t state_next;
  bit_count_t bit_cnt;     // Bits left in the current phase
  cmd_frame_t shift_reg;   // Command out, response in
  cmd_index_t saved_index;
  logic       crc_failed;

  logic crc_clear;
  logic crc_data;
  logic crc_unload;
  logic crc_bit;

  logic last_bit;
  logic load_frame;
  logic long_resp;
  logic no_resp;
  logic skip_crc;

  assign last_bit   = (bit_cnt == bit_count_t'(1));
  assign load_frame = (state == IDLE) && (req_go || crc_failed);

  // Per-command behavior
  assign long_resp = (saved_index == CMD_ALL_SEND_CID);
  assign no_resp   = (saved_index == CMD_GO_INACTIVE);
  assign skip_crc  = (saved_index == ACMD_SEND_OP_COND);

  // ==========================================================================
  // CRC7
  // ==========================================================================
  // Held clear until the first bit of either frame; the response start bit
  // is absorbed in WAIT_RESP on the cycle cmd_in goes low
  assign crc_clear  = irst || (state == IDLE) || ((state == WAIT_RESP) && cmd_in);
  assign crc_data   = (state == SEND_CMD) ? shift_reg[CMD_CONTENT_BITS-1] : cmd_in;
  assign crc_unload = (state == SEND_CRC) || (state == RCV_CRC);

  crc7 u_crc7 (
    .iclk    (iclk),
    .clear   (crc_clear),
    .data    (crc_data),
    .unload  (crc_unload),
    .crc_bit (crc_bit)
  );

  // ==========================================================================
  // State machine
  // ==========================================================================
  always_comb begin
    state_next = state;
    case (state)
      IDLE:      if (load_frame) state_next = SEND_CMD;
      SEND_CMD:  if (last_bit)   state_next = SEND_CRC;
      SEND_CRC: begin
        if (last_bit) begin
          state_next = no_resp ? IDLE : WAIT_RESP;
        end
      end
      WAIT_RESP: if (!cmd_in)    state_next = RCV_RESP; // Start bit seen
      RCV_RESP:  if (last_bit)   state_next = RCV_CRC;
      RCV_CRC:   if (last_bit)   state_next = IDLE;
      default:                   state_next = IDLE;
    endcase
  end

  always_ff @(posedge iclk) begin
    if (irst) begin
      state      <= IDLE;
      bit_cnt    <= '0;
      crc_failed <= 1'b0;
    end else begin
      state <= state_next;
      case (state)
        IDLE: begin
          if (load_frame) begin
            bit_cnt    <= bit_count_t'(CMD_CONTENT_BITS);
            crc_failed <= 1'b0; // Retry consumed
          end
        end
        SEND_CMD: begin
          bit_cnt <= last_bit ? bit_count_t'(CRC_FIELD_BITS) : bit_cnt - 1'b1;
        end
        SEND_CRC: begin
          bit_cnt <= bit_cnt - 1'b1;
        end
        WAIT_RESP: begin
          if (!cmd_in) begin
            bit_cnt <= long_resp ? bit_count_t'(RESP_LONG_BITS)
                                 : bit_count_t'(RESP_SHORT_BITS);
          end
        end
        RCV_RESP: begin
          bit_cnt <= last_bit ? bit_count_t'(CRC_FIELD_BITS) : bit_cnt - 1'b1;
        end
        RCV_CRC: begin
          bit_cnt <= bit_cnt - 1'b1;
          // Seven CRC bits compared, end bit ignored
          if (!last_bit && !skip_crc && (cmd_in != crc_bit)) begin
            crc_failed <= 1'b1;
          end
        end
        default: bit_cnt <= '0;
      endcase
    end
  end

  // ==========================================================================
  // Frame shift register
  // ==========================================================================
  // Resend reloads from the request side, which holds its fields while busy
  always_ff @(posedge iclk) begin
    if (load_frame) begin
      shift_reg   <= {1'b0, 1'b1, req_index, req_arg}; // Start, transmit
      saved_index <= req_index;
    end else if (state == SEND_CMD) begin
      shift_reg <= {shift_reg[CMD_CONTENT_BITS-2:0], 1'b0};
    end else if (state == RCV_RESP) begin
      shift_reg <= {shift_reg[CMD_CONTENT_BITS-2:0], cmd_in};
    end
  end

  // Outputs
  always_comb begin
    case (state)
      SEND_CMD: cmd_out = shift_reg[CMD_CONTENT_BITS-1];
      SEND_CRC: cmd_out = last_bit ? 1'b1 : crc_bit; // End bit last
      default:  cmd_out = 1'b1;
    endcase
  end

  assign frame     = shift_reg;
  assign done      = (state == IDLE) && !crc_failed;
  assign crc_retry = (state == IDLE) && crc_failed; // The pass-through cycle

endmodule

// ==== rtl/cmd_request.sv ====
// Host command request capture
`timescale 1ns/1ns

module cmd_request
  import sd_cmd_pkg::*;
(
  input  logic       iclk,
  input  logic       irst,
  input  logic       start,     // Level from host logic
  input  cmd_index_t cmd_index,
  input  cmd_arg_t   cmd_arg,
  input  logic       busy,      // Sequencer not idle
  output logic       req_go,    // One-cycle request pulse
  output cmd_index_t req_index,
  output cmd_arg_t   req_arg
);

  logic start_q;
  logic start_edge;

  // Only a fresh rising edge counts, and only while the line is free
  assign start_edge = start & ~start_q & ~busy;

  always_ff @(posedge iclk) begin
    if (irst) begin
      start_q <= 1'b0;
      req_go  <= 1'b0;
    end else begin
      start_q <= start;
      req_go  <= start_edge; // One cycle after the edge
    end
  end

  // Fields stay put for the whole transfer, retries included
  always_ff @(posedge iclk) begin
    if (start_edge) begin
      req_index <= cmd_index;
      req_arg   <= cmd_arg;
    end
  end

endmodule

// ==== rtl/resp_capture.sv ====
// Response capture and retry count
`timescale 1ns/1ns

module resp_capture
  import sd_cmd_pkg::*;
  import sd_host_pkg::*;
(
  input  logic         iclk,
  input  logic         irst,
  input  logic         done,
  input  logic         crc_retry,
  input  logic         req_go,
  input  cmd_frame_t   frame,
  output logic         resp_valid,
  output cmd_arg_t     resp,
  output cmd_index_t   resp_index,
  output retry_count_t retries
);

  logic done_q;
  logic done_rise;
  logic req_go_q;
  logic expect_resp;
  logic capture;

  assign done_rise = done & ~done_q;
  assign capture   = done_rise & expect_resp;

  always_ff @(posedge iclk) begin
    if (irst) begin
      done_q      <= 1'b1; // Sequencer comes out of reset idle
      req_go_q    <= 1'b0;
      expect_resp <= 1'b0;
      resp_valid  <= 1'b0;
      retries     <= '0;
    end else begin
      done_q     <= done;
      req_go_q   <= req_go;
      resp_valid <= capture;

      // Frame holds the new command one cycle after req_go
      if (req_go_q) begin
        expect_resp <= (frame[FRAME_INDEX_MSB:FRAME_INDEX_LSB] != CMD_GO_INACTIVE);
      end else if (done_rise) begin
        expect_resp <= 1'b0;
      end

      if (req_go) begin
        retries <= '0;
      end else if (crc_retry && (retries != RETRY_MAX)) begin
        retries <= retries + 1'b1; // Saturating
      end
    end
  end

  // Held until the next finished response
  always_ff @(posedge iclk) begin
    if (capture) begin
      resp       <= frame[FRAME_INDEX_LSB-1:0];
      resp_index <= frame[FRAME_INDEX_MSB:FRAME_INDEX_LSB];
    end
  end

endmodule

// ==== rtl/sd_cmd_top.sv ====
// SD host command path top level
`timescale 1ns/1ns

module sd_cmd_top
  import sd_cmd_pkg::*;
  import sd_host_pkg::*;
(
  input  logic         iclk,
  input  logic         irst,
  // Host request
  input  logic         start,
  input  cmd_index_t   cmd_index,
  input  cmd_arg_t     cmd_arg,
  // CMD line
  input  logic         cmd_in,
  output logic         cmd_out,
  // Host status and response
  output logic         busy,
  output logic         resp_valid,
  output cmd_arg_t     resp,
  output cmd_index_t   resp_index,
  output retry_count_t retries
);

  logic       req_go;
  cmd_index_t req_index;
  cmd_arg_t   req_arg;
  cmd_frame_t frame;
  logic       done;
  logic       crc_retry;

  assign busy = ~done;

  cmd_request u_cmd_request (
    .iclk      (iclk),
    .irst      (irst),
    .start     (start),
    .cmd_index (cmd_index),
    .cmd_arg   (cmd_arg),
    .busy      (busy),
    .req_go    (req_go),
    .req_index (req_index),
    .req_arg   (req_arg)
  );

  cmd_driver u_cmd_driver (
    .iclk      (iclk),
    .irst      (irst),
    .req_go    (req_go),
    .req_index (req_index),
    .req_arg   (req_arg),
    .cmd_in    (cmd_in),
    .cmd_out   (cmd_out),
    .frame     (frame),
    .done      (done),
    .crc_retry (crc_retry)
  );

  resp_capture u_resp_capture (
    .iclk       (iclk),
    .irst       (irst),
    .done       (done),
    .crc_retry  (crc_retry),
    .req_go     (req_go),
    .frame      (frame),
    .resp_valid (resp_valid),
    .resp       (resp),
    .resp_index (resp_index),
    .retries    (retries)
  );

endmodule

// ==== tb/tb_clock.sv ====
// Testbench clock and reset
`timescale 1ns/1ns

module tb_clock (
  output logic iclk,
  output logic irst
);

  // 20 ns period
  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;
  end

  // Reset seen by the DUT on three rising edges
  initial begin
    irst = 1'b1;
    repeat (3) @(posedge iclk);
    irst <= 1'b0;
  end

endmodule

// ==== tb/sd_card_model.sv ====
// Behavioral SD card on the CMD line
`timescale 1ns/1ns

module sd_card_model
  import sd_cmd_pkg::*;
(
  input  logic        iclk,
  input  logic        host_cmd,   // Host CMD output
  input  logic        corrupt,    // Damage the response CRC of this attempt
  output logic        card_cmd,   // Drives the host CMD input
  output int          cmd_count,  // Commands received so far
  output logic [47:0] last_frame  // Latest command, start bit in bit 47
);

  localparam cmd_arg_t RESP_MASK = 32'h5a5a_0f0f;

  // ==========================================================================
  // CRC7 over the top len bits, MSB first
  // ==========================================================================
  function automatic crc7_t crc7_of(input logic [135:0] bits, input int len);
    crc7_t crc;
    logic  fb;
    crc = '0;
    for (int i = len - 1; i >= 0; i--) begin
      fb  = bits[i] ^ crc[6];
      crc = {crc[5:0], 1'b0};
      if (fb) begin
        crc = crc ^ 7'h09; // x^7 + x^3 + 1
      end
    end
    return crc;
  endfunction

  // ==========================================================================
  // Response transmitter
  // ==========================================================================
  task automatic send_response(input cmd_index_t idx, input cmd_arg_t arg,
                               input logic flip);
    logic [135:0] bits;
    logic [127:0] fill;
    cmd_arg_t     payload;
    crc7_t        crc;
    int           len;
    int           gap;
    int           flip_pos;
    payload = arg ^ RESP_MASK;
    bits    = '0;
    if (idx == CMD_ALL_SEND_CID) begin
      // Start, transmit 0, reserved ones, filler, then index and payload last
      fill        = {$urandom, $urandom, $urandom, $urandom};
      bits[127:0] = {1'b0, 1'b0, 6'h3f, fill[81:0], idx, payload};
      len         = 128;
    end else begin
      bits[39:0] = {1'b0, 1'b0, idx, payload};
      len        = 40;
    end
    crc = crc7_of(bits, len);
    if (idx == ACMD_SEND_OP_COND) begin
      crc = 7'h7f; // R3 carries ones here
    end
    if (flip) begin
      flip_pos      = $urandom_range(6, 0);
      crc[flip_pos] = ~crc[flip_pos];
    end
    gap = $urandom_range(8, 2);
    repeat (gap) @(posedge iclk);
    for (int i = len - 1; i >= 0; i--) begin
      @(posedge iclk);
      card_cmd <= bits[i];
    end
    for (int i = 6; i >= 0; i--) begin
      @(posedge iclk);
      card_cmd <= crc[i];
    end
    @(posedge iclk);
    card_cmd <= 1'b1; // End bit, line stays high after
  endtask

  // ==========================================================================
  // Command receiver
  // ==========================================================================
  initial begin : card_loop
    logic [47:0] rx;
    logic        flip;
    card_cmd   = 1'b1;
    cmd_count  = 0;
    last_frame = '1;
    forever begin
      @(negedge iclk);
      if (host_cmd === 1'b0) begin
        flip = corrupt;  // Sampled at the start bit
        rx   = 48'h0;
        for (int i = 1; i < 48; i++) begin
          @(negedge iclk);
          rx = {rx[46:0], host_cmd};
        end
        cmd_count  <= cmd_count + 1;
        last_frame <= rx;
        if (rx[45:40] != CMD_GO_INACTIVE) begin
          send_response(rx[45:40], rx[39:8], flip);
        end
      end
    end
  end

endmodule

// ==== tb/tb_sd_cmd.sv ====
// SD command path testbench
`timescale 1ns/1ns

module tb_sd_cmd
  import sd_cmd_pkg::*;
  import sd_host_pkg::*;
();

  localparam int       NUM_CMDS       = 40;
  localparam int       CYCLES_PER_CMD = 400;
  localparam int       TIMEOUT_CYCLES = NUM_CMDS * CYCLES_PER_CMD;
  localparam cmd_arg_t RESP_MASK      = 32'h5a5a_0f0f;

  logic         iclk;
  logic         irst;
  logic         start;
  cmd_index_t   cmd_index;
  cmd_arg_t     cmd_arg;
  logic         cmd_in;
  logic         cmd_out;
  logic         busy;
  logic         resp_valid;
  cmd_arg_t     resp;
  cmd_index_t   resp_index;
  retry_count_t retries;

  logic         corrupt;
  int           card_cmds;
  logic [47:0]  card_frame;
  logic [47:0]  exp_frame;
  int           frames_checked = 0;
  int           valid_pulses = 0;
  int           busy_run = 0;
  int           cycles = 0;

  tb_clock u_clock (
    .iclk (iclk),
    .irst (irst)
  );

  sd_cmd_top uut (
    .iclk       (iclk),
    .irst       (irst),
    .start      (start),
    .cmd_index  (cmd_index),
    .cmd_arg    (cmd_arg),
    .cmd_in     (cmd_in),
    .cmd_out    (cmd_out),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp       (resp),
    .resp_index (resp_index),
    .retries    (retries)
  );

  sd_card_model u_card (
    .iclk       (iclk),
    .host_cmd   (cmd_out),
    .corrupt    (corrupt),
    .card_cmd   (cmd_in),
    .cmd_count  (card_cmds),
    .last_frame (card_frame)
  );

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "check failed: %s", what);
    end
  endtask

  // Start 0, transmit 1, index, argument, CRC7, end 1
  function automatic logic [47:0] build_frame(input cmd_index_t idx, input cmd_arg_t arg);
    logic [39:0] content;
    crc7_t       crc;
    logic        fb;
    content = {2'b01, idx, arg};
    crc     = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = content[i] ^ crc[6];
      crc = {crc[5:0], 1'b0};
      if (fb) begin
        crc = crc ^ 7'h09;
      end
    end
    return {content, crc, 1'b1};
  endfunction

  function automatic cmd_index_t pick_index();
    case ($urandom_range(4, 0))
      0:       return 6'd2;
      1:       return 6'd8;
      2:       return 6'd15;
      3:       return 6'd41;
      default: return cmd_index_t'($urandom);
    endcase
  endfunction

  task automatic wait_busy(input logic level);
    do @(negedge iclk); while (busy !== level);
  endtask

  // ==========================================================================
  // One command from start edge to response
  // ==========================================================================
  task automatic run_command(input cmd_index_t idx, input cmd_arg_t arg,
                             input logic bad, input logic hold);
    logic has_resp;
    logic retry_exp;
    int   cmds_before;
    int   pulses_before;
    has_resp      = (idx != 6'd15);
    retry_exp     = bad && has_resp && (idx != 6'd41);
    cmds_before   = card_cmds;
    pulses_before = valid_pulses;
    @(posedge iclk);
    exp_frame = build_frame(idx, arg);
    busy_run  <= 0;
    start     <= 1'b1;
    cmd_index <= idx;
    cmd_arg   <= arg;
    corrupt   <= bad;
    wait_busy(1'b1);
    @(posedge iclk);
    corrupt   <= 1'b0;
    cmd_index <= cmd_index_t'($urandom); // Request side must hold its copy
    cmd_arg   <= $urandom;
    if (!hold) begin
      start <= 1'b0;
      @(posedge iclk);
      start <= 1'b1; // Edge while busy
      @(posedge iclk);
      start <= 1'b0;
    end
    wait_busy(1'b0);
    @(posedge iclk);
    start <= 1'b0;
    repeat (3) @(negedge iclk);
    check(valid_pulses - pulses_before, has_resp ? 1 : 0, "resp_valid pulse count");
    check(card_cmds - cmds_before, retry_exp ? 2 : 1, "commands seen by card");
    check(retries, retry_exp ? 1 : 0, "retry count");
    check(busy, 1'b0, "busy after completion"); // A held start must not restart
    if (has_resp) begin
      check(resp, arg ^ RESP_MASK, "response payload");
      check(resp_index, idx, "response index");
    end else begin
      check(busy_run, 48, "busy cycles without response");
    end
  endtask

  // Monitors
  always @(negedge iclk) begin
    if (resp_valid) valid_pulses <= valid_pulses + 1;
    if (busy) busy_run <= busy_run + 1;
    if (card_cmds != frames_checked) begin
      check(card_frame, exp_frame, "command frame");
      frames_checked <= card_cmds;
    end
  end

  always @(posedge iclk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run stopped: timeout after %0d cycles", cycles);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    int unsigned seed_state;
    start      = 1'b0;
    cmd_index  = '0;
    cmd_arg    = '0;
    corrupt    = 1'b0;
    exp_frame  = '1;
    seed_state = $urandom(32'h2ff2);
    do @(negedge iclk); while (irst);
    check(cmd_out, 1'b1, "cmd_out after reset");
    check(busy, 1'b0, "busy after reset");
    check(resp_valid, 1'b0, "resp_valid after reset");
    check(retries, 0, "retries after reset");
    for (int n = 0; n < NUM_CMDS; n++) begin
      run_command(pick_index(), $urandom, $urandom_range(1, 0) == 1,
                  $urandom_range(1, 0) == 1);
    end
    $display("Ran %0d commands, card saw %0d frames", NUM_CMDS, card_cmds);
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== compile.f ====
common/sd_cmd_pkg.sv
common/sd_host_pkg.sv
cmd_line/crc7.sv
cmd_line/cmd_driver.sv
rtl/cmd_request.sv
rtl/resp_capture.sv
rtl/sd_cmd_top.sv
tb/tb_clock.sv
tb/sd_card_model.sv
tb/tb_sd_cmd.sv
